// File: Makefile
# Verilator build and run for the puzzle display testbench

VERILATOR ?= verilator
TOP       ?= tb_puzzle_display
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
design/puzzle_pkg.sv
design/pixel_write_if.sv
design/pixel_packer.sv
design/picture_ram.sv
design/tile_renderer.sv
design/puzzle_display_top.sv
testbench/tb_puzzle_display.sv

// File: design/picture_ram.sv
`timescale 1ns/1ps

module picture_ram (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [puzzle_pkg::ADDR_BITS-1:0] rd_addr,
    output puzzle_pkg::color_t             rd_data,
    pixel_write_if.slave                   wr
);
    import puzzle_pkg::*;

    color_t mem [PICTURE_PIXELS];

    // write side of the handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.ack <= 1'b0;
        end else if (wr.req && !wr.ack) begin
            wr.ack <= 1'b1;     // write lands on this same edge
        end else if (!wr.req && wr.ack) begin
            wr.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.req && !wr.ack)
            mem[wr.addr] <= wr.data;
    end

    // read port for the renderer, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // master has to keep req up until it has seen ack
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wr.ack) |-> wr.req
    ) else $error("ack rose while req was low");

endmodule

// File: design/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          byte_req,
    input  logic [7:0]    byte_data,
    output logic          byte_ack,
    pixel_write_if.master wr
);
    import puzzle_pkg::*;

    // position of the next byte inside a three-byte group
    typedef enum logic [1:0] {
        PH_RG,  // red and green of p0
        PH_BR,  // blue of p0, red of p1
        PH_GB   // green and blue of p1
    } phase_t;

    phase_t     phase;
    logic [7:0] rg_hold;    // first byte, waits for its blue nibble
    logic [3:0] nib_hold;   // red nibble of the second pixel
    logic       wr_busy;
    logic       take_byte;

    // a write counts as busy until the RAM has dropped ack again
    assign wr_busy   = wr.req | wr.ack;
    assign take_byte = byte_req & ~byte_ack & ~wr_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_RG;
            byte_ack <= 1'b0;
            wr.req   <= 1'b0;
            wr.addr  <= '0;
        end else begin
            if (take_byte)
                byte_ack <= 1'b1;
            else if (byte_ack && !byte_req)
                byte_ack <= 1'b0;   // source has let go

            if (take_byte) begin
                case (phase)
                    PH_RG: phase <= PH_BR;
                    PH_BR: begin
                        wr.req <= 1'b1;  // p0 complete
                        phase  <= PH_GB;
                    end
                    PH_GB: begin
                        wr.req <= 1'b1;  // p1 complete
                        phase  <= PH_RG;
                    end
                    default: phase <= PH_RG;
                endcase
            end else if (wr.req && wr.ack) begin
                wr.req <= 1'b0;
                // step to the next pixel, wrapping at the end of the picture
                if (wr.addr == ADDR_BITS'(PICTURE_PIXELS - 1))
                    wr.addr <= '0;
                else
                    wr.addr <= wr.addr + 1'b1;
            end
        end
    end

    // byte payload, only sampled when a byte is taken
    always_ff @(posedge clk) begin
        if (take_byte) begin
            case (phase)
                PH_RG: rg_hold <= byte_data;
                PH_BR: begin
                    wr.data  <= {rg_hold, byte_data[7:4]};
                    nib_hold <= byte_data[3:0];
                end
                default: wr.data <= {nib_hold, byte_data};
            endcase
        end
    end

    // the RAM may sample the write at any cycle until it answers
    a_write_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr.req && !wr.ack) |=> ($stable(wr.addr) && $stable(wr.data))
    ) else $error("pixel write changed before ack, addr %h data %h", wr.addr, wr.data);

endmodule

// File: design/pixel_write_if.sv
`timescale 1ns/1ps

// four-phase pixel write from the packer into the picture RAM
interface pixel_write_if;
    import puzzle_pkg::*;

    logic                 req;   // held until ack is seen
    logic                 ack;   // follows req
    logic [ADDR_BITS-1:0] addr;
    color_t               data;

    modport master (
        output req,
        output addr,
        output data,
        input  ack
    );

    modport slave (
        input  req,
        input  addr,
        input  data,
        output ack
    );

endinterface

// File: design/puzzle_display_top.sv
`timescale 1ns/1ps

module puzzle_display_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                byte_req,
    input  logic [7:0]                          byte_data,
    output logic                                byte_ack,
    input  logic [puzzle_pkg::TILE_COUNT*$bits(puzzle_pkg::tile_idx_t)-1:0] tile_order,
    input  puzzle_pkg::tile_idx_t               blank_tile,
    input  logic                                display_en,
    input  logic [puzzle_pkg::COORD_BITS-1:0]   x,
    input  logic [puzzle_pkg::COORD_BITS-1:0]   y,
    output puzzle_pkg::color_t                  vga
);
    import puzzle_pkg::*;

    logic [ADDR_BITS-1:0] rd_addr;
    color_t               rd_data;

    pixel_write_if wr_bus ();   // packer to RAM

    pixel_packer pixel_packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_ack  (byte_ack),
        .wr        (wr_bus.master)
    );

    picture_ram picture_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr      (wr_bus.slave)
    );

    tile_renderer tile_renderer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .display_en (display_en),
        .x          (x),
        .y          (y),
        .tile_order (tile_order),
        .blank_tile (blank_tile),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .vga        (vga)
    );

endmodule

// File: design/puzzle_pkg.sv
package puzzle_pkg;

    // pixel colour, 4 bits each of red, green, blue from the top
    localparam int COLOR_BITS = 12;
    typedef logic [COLOR_BITS-1:0] color_t;

    localparam int COORD_BITS = 7;      // display x and y

    localparam int DISPLAY_WIDTH  = 64;
    localparam int DISPLAY_HEIGHT = 48;
    localparam int PICTURE_WIDTH  = 32;
    localparam int PICTURE_HEIGHT = 32;

    // puzzle grid
    localparam int TILE_SIZE  = 8;
    localparam int GRID_DIM   = PICTURE_WIDTH / TILE_SIZE;
    localparam int TILE_COUNT = GRID_DIM * GRID_DIM;

    // picture is centred in the display area
    localparam int X_GAP = (DISPLAY_WIDTH - PICTURE_WIDTH) / 2;
    localparam int Y_GAP = (DISPLAY_HEIGHT - PICTURE_HEIGHT) / 2;

    localparam int BORDER_SIZE = 2;

    localparam int PICTURE_PIXELS = PICTURE_WIDTH * PICTURE_HEIGHT;
    localparam int ADDR_BITS      = $clog2(PICTURE_PIXELS);  // row-major pixel address

    typedef logic [$clog2(TILE_COUNT)-1:0] tile_idx_t;

    localparam color_t BACKGROUND_COLOR = 12'h777;  // light gray
    localparam color_t BORDER_COLOR     = 12'h222;  // dark gray

endpackage

// File: design/tile_renderer.sv
`timescale 1ns/1ps

module tile_renderer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                display_en,
    input  logic [puzzle_pkg::COORD_BITS-1:0]   x,
    input  logic [puzzle_pkg::COORD_BITS-1:0]   y,
    input  logic [puzzle_pkg::TILE_COUNT*$bits(puzzle_pkg::tile_idx_t)-1:0] tile_order,
    input  puzzle_pkg::tile_idx_t               blank_tile,
    input  puzzle_pkg::color_t                  rd_data,
    output logic [puzzle_pkg::ADDR_BITS-1:0]    rd_addr,
    output puzzle_pkg::color_t                  vga
);
    import puzzle_pkg::*;

    typedef enum logic [2:0] {
        CLS_OFF,        // display disabled
        CLS_BACKGROUND,
        CLS_BORDER,
        CLS_PICTURE,
        CLS_BLANK       // the empty tile slot
    } pixel_class_t;

    logic                  in_picture;
    logic                  in_frame;
    logic [COORD_BITS-1:0] lx;          // picture-local coordinates
    logic [COORD_BITS-1:0] ly;
    logic [COORD_BITS-1:0] pic_row;     // source pixel inside the RAM picture
    logic [COORD_BITS-1:0] pic_col;
    logic [ADDR_BITS:0]    addr_full;
    tile_idx_t             slot;
    tile_idx_t             src_tile;
    pixel_class_t          cls_d;
    pixel_class_t          cls_q;

    // region tests on the raw display position
    assign in_picture = (x >= COORD_BITS'(X_GAP)) && (x < COORD_BITS'(X_GAP + PICTURE_WIDTH))
                     && (y >= COORD_BITS'(Y_GAP)) && (y < COORD_BITS'(Y_GAP + PICTURE_HEIGHT));

    assign in_frame = (x >= COORD_BITS'(X_GAP - BORDER_SIZE))
                   && (x < COORD_BITS'(X_GAP + PICTURE_WIDTH + BORDER_SIZE))
                   && (y >= COORD_BITS'(Y_GAP - BORDER_SIZE))
                   && (y < COORD_BITS'(Y_GAP + PICTURE_HEIGHT + BORDER_SIZE));

    assign lx = x - COORD_BITS'(X_GAP);
    assign ly = y - COORD_BITS'(Y_GAP);

    // screen slot, then the tile the order map places there
    assign slot     = tile_idx_t'((ly / TILE_SIZE) * GRID_DIM + lx / TILE_SIZE);
    assign src_tile = tile_order[slot * $bits(tile_idx_t) +: $bits(tile_idx_t)];

    assign pic_row = COORD_BITS'((src_tile / GRID_DIM) * TILE_SIZE + ly % TILE_SIZE);
    assign pic_col = COORD_BITS'((src_tile % GRID_DIM) * TILE_SIZE + lx % TILE_SIZE);

    // row-major, the RAM reads this while the class is registered
    assign addr_full = (ADDR_BITS + 1)'(pic_row * PICTURE_WIDTH + pic_col);
    assign rd_addr   = addr_full[ADDR_BITS-1:0];

    always_comb begin
        if (!display_en)
            cls_d = CLS_OFF;
        else if (in_picture)
            cls_d = (src_tile == blank_tile) ? CLS_BLANK : CLS_PICTURE;
        else if (in_frame)
            cls_d = CLS_BORDER;
        else
            cls_d = CLS_BACKGROUND;
    end

    // stage one holds the class, stage two the colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cls_q <= CLS_OFF;
            vga   <= '0;
        end else begin
            cls_q <= cls_d;
            case (cls_q)
                CLS_PICTURE:    vga <= rd_data;   // ram data lines up with cls_q
                CLS_BORDER:     vga <= BORDER_COLOR;
                CLS_BACKGROUND: vga <= BACKGROUND_COLOR;
                default:        vga <= '0;        // disabled or blank tile
            endcase
        end
    end

    // the tile mapping must never point past the stored picture
    a_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (display_en && in_picture) |-> (addr_full < (ADDR_BITS + 1)'(PICTURE_PIXELS))
    ) else $error("rd_addr out of range, %h", addr_full);

endmodule

// File: testbench/tb_puzzle_display.sv
`timescale 1ns/1ps

module tb_puzzle_display;
    import puzzle_pkg::*;

    localparam int HALF_PERIOD   = 50;     // 100 ns clock
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int IDX_BITS      = $bits(tile_idx_t);
    localparam int ORDER_BITS    = TILE_COUNT * IDX_BITS;
    localparam int PICTURE_BYTES = PICTURE_PIXELS * 3 / 2;
    localparam int SCAN_CYCLES   = DISPLAY_WIDTH * DISPLAY_HEIGHT;
    // up to 12 cycles per byte, four full scans, some slack
    localparam int TIMEOUT_CYCLES = PICTURE_BYTES * 12 + 4 * SCAN_CYCLES + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  byte_req;
    logic [7:0]            byte_data;
    logic                  byte_ack;
    logic [ORDER_BITS-1:0] tile_order;
    tile_idx_t             blank_tile;
    logic                  display_en;
    logic [COORD_BITS-1:0] x;
    logic [COORD_BITS-1:0] y;
    color_t                vga;

    color_t      model_pic [PICTURE_PIXELS];  // expected RAM contents
    int unsigned model_addr;
    int unsigned lcg_state;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    logic        check_en;
    logic        skip_picture;    // frame test, RAM contents unknown

    puzzle_display_top puzzle_display_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_req   (byte_req),
        .byte_data  (byte_data),
        .byte_ack   (byte_ack),
        .tile_order (tile_order),
        .blank_tile (blank_tile),
        .display_en (display_en),
        .x          (x),
        .y          (y),
        .vga        (vga)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic bit in_picture_area(input int px, input int py);
        return px >= X_GAP && px < X_GAP + PICTURE_WIDTH
            && py >= Y_GAP && py < Y_GAP + PICTURE_HEIGHT;
    endfunction

    // colour rule applied to the model picture
    function automatic color_t expected_pixel(input int px, input int py, input logic en,
                                              input logic [ORDER_BITS-1:0] order,
                                              input tile_idx_t blank);
        int lx;
        int ly;
        int slot;
        int src;
        lx = px - X_GAP;
        ly = py - Y_GAP;
        if (!en)
            return '0;
        if (in_picture_area(px, py)) begin
            slot = (ly / TILE_SIZE) * GRID_DIM + lx / TILE_SIZE;
            src  = int'(order[slot*IDX_BITS +: IDX_BITS]);
            if (src == int'(blank))
                return '0;
            return model_pic[((src / GRID_DIM) * TILE_SIZE + ly % TILE_SIZE) * PICTURE_WIDTH
                             + (src % GRID_DIM) * TILE_SIZE + lx % TILE_SIZE];
        end
        if (lx >= -BORDER_SIZE && lx < PICTURE_WIDTH + BORDER_SIZE
            && ly >= -BORDER_SIZE && ly < PICTURE_HEIGHT + BORDER_SIZE)
            return BORDER_COLOR;
        return BACKGROUND_COLOR;
    endfunction

    function automatic logic [ORDER_BITS-1:0] identity_order();
        logic [ORDER_BITS-1:0] order;
        for (int i = 0; i < TILE_COUNT; i++)
            order[i*IDX_BITS +: IDX_BITS] = tile_idx_t'(i);
        return order;
    endfunction

    // Fisher-Yates over the tile numbers
    function automatic logic [ORDER_BITS-1:0] shuffled_order();
        tile_idx_t             perm [TILE_COUNT];
        tile_idx_t             tmp;
        logic [ORDER_BITS-1:0] order;
        int                    j;
        for (int i = 0; i < TILE_COUNT; i++)
            perm[i] = tile_idx_t'(i);
        for (int i = TILE_COUNT - 1; i > 0; i--) begin
            j       = int'(lcg_next()) % (i + 1);
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int i = 0; i < TILE_COUNT; i++)
            order[i*IDX_BITS +: IDX_BITS] = perm[i];
        return order;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] value);
        int gap;
        byte_data = value;
        byte_req  = 1'b1;
        do next_cycle(); while (!byte_ack);
        byte_req = 1'b0;
        do next_cycle(); while (byte_ack);
        gap = int'(lcg_next()) % 4;     // 0 to 3 idle cycles
        repeat (gap) next_cycle();
    endtask

    task automatic model_write(input color_t pixel);
        model_pic[model_addr] = pixel;
        model_addr = (model_addr + 1) % PICTURE_PIXELS;
    endtask

    // three random bytes, two pixels
    task automatic send_random_pair();
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        b0 = 8'(lcg_next());
        b1 = 8'(lcg_next());
        b2 = 8'(lcg_next());
        send_byte(b0);
        send_byte(b1);
        model_write({b0, b1[7:4]});
        send_byte(b2);
        model_write({b1[3:0], b2});
    endtask

    // last pixel write may still be on the internal bus
    task automatic wait_write_idle();
        do next_cycle();
        while (puzzle_display_top_i.wr_bus.req || puzzle_display_top_i.wr_bus.ack);
    endtask

    task automatic scan_area(input int x_lo, input int y_lo, input int width, input int height,
                             input logic en, input logic skip_pic);
        display_en   = en;
        skip_picture = skip_pic;
        check_en     = 1'b1;
        for (int py = y_lo; py < y_lo + height; py++) begin
            for (int px = x_lo; px < x_lo + width; px++) begin
                x = COORD_BITS'(px);
                y = COORD_BITS'(py);
                next_cycle();
            end
        end
        check_en = 1'b0;
        repeat (3) next_cycle();    // drain the pipeline
    endtask

    task automatic check_idle_outputs();
        assert (byte_ack === 1'b0) else begin
            $display("** Error: byte_ack = %h, expected 0", byte_ack);
            errors++;
        end
        assert (vga === '0) else begin
            $display("** Error: vga = %h, expected 000", vga);
            errors++;
        end
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - test_start_errors);
        end
    endtask

    // inputs sampled at edge n sit on vga from edge n+1 up to edge n+2
    initial begin : compare_vga
        color_t exp_pipe [2];
        logic   chk_pipe [2];
        int     x_pipe   [2];
        int     y_pipe   [2];
        for (int i = 0; i < 2; i++)
            chk_pipe[i] = 1'b0;
        forever begin
            @(posedge clk);
            exp_pipe[1] = exp_pipe[0];
            chk_pipe[1] = chk_pipe[0];
            x_pipe[1]   = x_pipe[0];
            y_pipe[1]   = y_pipe[0];
            exp_pipe[0] = expected_pixel(x, y, display_en, tile_order, blank_tile);
            chk_pipe[0] = check_en && !(skip_picture && in_picture_area(x, y));
            x_pipe[0]   = x;
            y_pipe[0]   = y;
            @(negedge clk);
            if (chk_pipe[1]) begin
                assert (vga === exp_pipe[1]) else begin
                    $display("** Error: vga = %h, expected %h at x %0d y %0d",
                             vga, exp_pipe[1], x_pipe[1], y_pipe[1]);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        byte_req     = 1'b0;
        byte_data    = '0;
        tile_order   = identity_order();
        blank_tile   = tile_idx_t'(TILE_COUNT - 1);
        display_en   = 1'b0;
        x            = '0;
        y            = '0;
        check_en     = 1'b0;
        skip_picture = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 83;
        model_addr   = 0;
        foreach (model_pic[i])
            model_pic[i] = '0;

        start_test();
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (4) begin
            next_cycle();
            check_idle_outputs();
        end
        report_test("reset");

        start_test();
        scan_area(0, 0, DISPLAY_WIDTH, DISPLAY_HEIGHT, 1'b0, 1'b0);
        report_test("disabled output");

        start_test();
        scan_area(0, 0, DISPLAY_WIDTH, DISPLAY_HEIGHT, 1'b1, 1'b1);
        report_test("frame");

        start_test();
        for (int g = 0; g < PICTURE_BYTES / 3; g++)
            send_random_pair();
        wait_write_idle();
        scan_area(0, 0, DISPLAY_WIDTH, DISPLAY_HEIGHT, 1'b1, 1'b0);
        report_test("identity layout");

        start_test();
        tile_order = shuffled_order();
        blank_tile = tile_idx_t'(lcg_next());
        scan_area(0, 0, DISPLAY_WIDTH, DISPLAY_HEIGHT, 1'b1, 1'b0);
        report_test("permuted layout");

        start_test();
        send_random_pair();     // address has wrapped, lands on pixels 0 and 1
        wait_write_idle();
        tile_order = identity_order();
        blank_tile = tile_idx_t'(TILE_COUNT - 1);
        scan_area(X_GAP, Y_GAP, TILE_SIZE, TILE_SIZE, 1'b1, 1'b0);
        report_test("address wrap");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
